// File: src/otter_pipe_top.sv
`timescale 1ns/10ps
`include "rv_config.svh"

module otter_pipe_top (
    input  logic          CLK,
    input  logic          rst_n,
    input  logic          run,
    input  logic          imem_we,
    input  rv_pkg::word_t imem_addr,
    input  rv_pkg::word_t imem_wdata,
    input  rv_pkg::word_t io_in,
    output rv_pkg::word_t io_addr,
    output rv_pkg::word_t io_wdata,
    output logic          io_wr
);
    localparam rv_pkg::stage_ctrl_t CTRL_BUBBLE = '{opcode: rv_pkg::opc_nop,
                                                    alu_fun: rv_pkg::alu_add,
                                                    invalid: 1'b1,
                                                    default: '0};

    rv_pkg::word_t       pc, if_id_pc, instr;
    logic                id_valid;                // IF/ID holds a fetched slot
    rv_pkg::word_t       rs1_data, rs2_data;
    rv_pkg::stage_ctrl_t de_ctrl, ex_ctrl, mem_ctrl, wb_ctrl;
    rv_pkg::word_t       de_a, de_b, de_store, de_imm;
    rv_pkg::word_t       ex_a, ex_b, ex_store, ex_imm;
    rv_pkg::fwd_sel_t    sel_a, sel_b, sel_store;
    rv_pkg::word_t       ex_result, ex_store_fwd, target;
    rv_pkg::word_t       mem_result, mem_store, mem_rdata;
    rv_pkg::word_t       wb_result, wb_load, wb_data;
    logic                stall, redirect, squash;

    //////////////////////////////////////////////////////////////////////////
    // Fetch
    always_ff @(posedge CLK)
    begin
        if (!rst_n)
        begin
            pc       <= `RV_RESET_PC;
            if_id_pc <= `RV_RESET_PC;
            id_valid <= 1'b0;
        end
        else
        begin
            if (redirect)
                pc <= target;              // Taken branch or JAL
            else if (run && !stall)
                pc <= pc + 32'd4;
            if (run && !stall)
                if_id_pc <= pc;
            if (run)
                id_valid <= 1'b1;          // First run cycle decodes nothing
        end
    end

    // Both younger slots die: decode now, and the one behind it next cycle
    assign squash = redirect || mem_ctrl.br_taken;

    //////////////////////////////////////////////////////////////////////////
    // Decode
    rv_regfile u_regfile (
        .CLK(CLK), .rs1_addr(instr[19:15]), .rs2_addr(instr[24:20]),
        .wr_addr(wb_ctrl.rd), .wr_data(wb_data), .wr_en(wb_ctrl.reg_write),
        .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    rv_decode u_decode (
        .instr(instr), .pc(if_id_pc), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .ex_ctrl(ex_ctrl), .squash(squash), .run(run && id_valid),
        .ctrl(de_ctrl), .op_a(de_a), .op_b(de_b), .store_data(de_store),
        .imm(de_imm), .stall(stall)
    );

    //////////////////////////////////////////////////////////////////////////
    // Pipeline control registers
    always_ff @(posedge CLK)
    begin
        if (!rst_n)
        begin
            ex_ctrl  <= CTRL_BUBBLE;
            mem_ctrl <= CTRL_BUBBLE;
            wb_ctrl  <= CTRL_BUBBLE;
        end
        else
        begin
            ex_ctrl           <= de_ctrl;
            mem_ctrl          <= ex_ctrl;
            mem_ctrl.br_taken <= redirect;   // Marks the slot that redirected
            wb_ctrl           <= mem_ctrl;
        end
    end

    // Operand and result words
    always_ff @(posedge CLK)
    begin
        ex_a       <= de_a;
        ex_b       <= de_b;
        ex_store   <= de_store;
        ex_imm     <= de_imm;
        mem_result <= ex_result;
        mem_store  <= ex_store_fwd;
        wb_result  <= mem_result;
        wb_load    <= mem_rdata;
    end

    //////////////////////////////////////////////////////////////////////////
    // Execute
    rv_forward u_forward (
        .ex_ctrl(ex_ctrl), .mem_ctrl(mem_ctrl), .wb_ctrl(wb_ctrl),
        .sel_a(sel_a), .sel_b(sel_b), .sel_store(sel_store)
    );

    rv_execute u_execute (
        .ctrl(ex_ctrl), .op_a(ex_a), .op_b(ex_b), .store_in(ex_store), .imm(ex_imm),
        .mem_result(mem_result), .wb_result(wb_result), .load_data(wb_load),
        .sel_a(sel_a), .sel_b(sel_b), .sel_store(sel_store),
        .result(ex_result), .store_data(ex_store_fwd), .redirect(redirect),
        .target(target)
    );

    //////////////////////////////////////////////////////////////////////////
    // Memory and writeback
    rv_memory u_memory (
        .CLK(CLK), .imem_we(imem_we), .imem_addr(imem_addr), .imem_wdata(imem_wdata),
        .fetch_pc(if_id_pc),   // Registered fetch address lines up with decode
        .addr(mem_result), .wdata(mem_store), .we(mem_ctrl.mem_write), .io_in(io_in),
        .instr(instr), .rdata(mem_rdata),
        .io_addr(io_addr), .io_wdata(io_wdata), .io_wr(io_wr)
    );

    assign wb_data = wb_ctrl.wb_sel ? wb_load : wb_result;  // Load data or ALU/link

endmodule

// File: src/rv_config.svh
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// Memory sizes, in 32-bit words
`define RV_IMEM_WORDS 256
`define RV_DMEM_WORDS 256

// Address bit that steers a data access to the io ports
`define RV_IO_BIT 31

// First instruction fetched after reset
`define RV_RESET_PC 32'h0000_0000

`endif

// File: src/rv_decode.sv
`timescale 1ns/10ps

module rv_decode (
    input  rv_pkg::word_t       instr,
    input  rv_pkg::word_t       pc,
    input  rv_pkg::word_t       rs1_data,
    input  rv_pkg::word_t       rs2_data,
    input  rv_pkg::stage_ctrl_t ex_ctrl,
    input  logic                squash,
    input  logic                run,
    output rv_pkg::stage_ctrl_t ctrl,
    output rv_pkg::word_t       op_a,
    output rv_pkg::word_t       op_b,
    output rv_pkg::word_t       store_data,
    output rv_pkg::word_t       imm,
    output logic                stall
);
    rv_pkg::word_t       i_imm, s_imm, u_imm, b_imm, j_imm;
    rv_pkg::stage_ctrl_t dec;   // Raw decode, before bubble insertion
    logic [2:0]          funct3;

    assign funct3 = instr[14:12];
    assign i_imm  = {{20{instr[31]}}, instr[31:20]};
    assign s_imm  = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign u_imm  = {instr[31:12], 12'b0};
    assign b_imm  = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign j_imm  = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb
    begin
        dec         = '0;
        dec.opcode  = rv_pkg::opc_nop;
        dec.alu_fun = rv_pkg::alu_add;
        dec.rs1     = instr[19:15];
        dec.rs2     = instr[24:20];
        dec.rd      = instr[11:7];
        dec.pc      = pc;
        dec.funct3  = funct3;
        op_a        = rs1_data;
        op_b        = i_imm;   // I-type unless overridden
        imm         = b_imm;   // Target offset, used only by BRANCH and JAL
        case (instr[6:0])
            rv_pkg::opc_lui:
            begin
                dec.opcode    = rv_pkg::opc_lui;
                dec.alu_fun   = rv_pkg::alu_lui;
                dec.reg_write = 1'b1;
                op_b          = u_imm;
            end
            rv_pkg::opc_jal:
            begin
                dec.opcode    = rv_pkg::opc_jal;
                dec.reg_write = 1'b1;   // Link comes from execute
                imm           = j_imm;
            end
            rv_pkg::opc_branch:
            begin
                dec.opcode   = rv_pkg::opc_branch;
                dec.rs1_used = 1'b1;
                dec.rs2_used = 1'b1;
                op_b         = rs2_data;  // Compare operand
            end
            rv_pkg::opc_load:
            begin
                dec.opcode    = rv_pkg::opc_load;
                dec.rs1_used  = 1'b1;
                dec.mem_read  = 1'b1;
                dec.reg_write = 1'b1;
                dec.wb_sel    = 1'b1;
            end
            rv_pkg::opc_store:
            begin
                dec.opcode    = rv_pkg::opc_store;
                dec.rs1_used  = 1'b1;
                dec.rs2_used  = 1'b1;
                dec.mem_write = 1'b1;
                op_b          = s_imm;
            end
            rv_pkg::opc_op_imm:
            begin
                dec.opcode    = rv_pkg::opc_op_imm;
                dec.rs1_used  = 1'b1;
                dec.reg_write = 1'b1;
                // Only SRAI uses bit 30 as a function bit
                dec.alu_fun   = rv_pkg::alu_fun_t'({funct3 == 3'b101 && instr[30], funct3});
            end
            rv_pkg::opc_op:
            begin
                dec.opcode    = rv_pkg::opc_op;
                dec.rs1_used  = 1'b1;
                dec.rs2_used  = 1'b1;
                dec.reg_write = 1'b1;
                dec.alu_fun   = rv_pkg::alu_fun_t'({instr[30], funct3});
                op_b          = rs2_data;
            end
            default: dec.invalid = 1'b1;  // Unsupported or unwritten word
        endcase
        dec.ld_haz = dec.mem_read && dec.rd != '0;
    end

    assign store_data = rs2_data;  // Forwarded later in execute

    // Load in execute feeding a source here: hold one cycle
    assign stall = run && !squash && ex_ctrl.ld_haz &&
                   ((dec.rs1_used && dec.rs1 == ex_ctrl.rd) ||
                    (dec.rs2_used && dec.rs2 == ex_ctrl.rd));

    always_comb
    begin
        ctrl = dec;
        if (stall || squash || !run)   // Bubble with all side effects off
        begin
            ctrl.invalid   = 1'b1;
            ctrl.mem_write = 1'b0;
            ctrl.mem_read  = 1'b0;
            ctrl.reg_write = 1'b0;
            ctrl.ld_haz    = 1'b0;
        end
    end

endmodule

// File: src/rv_execute.sv
`timescale 1ns/10ps

module rv_execute (
    input  rv_pkg::stage_ctrl_t ctrl,
    input  rv_pkg::word_t       op_a,
    input  rv_pkg::word_t       op_b,
    input  rv_pkg::word_t       store_in,
    input  rv_pkg::word_t       imm,
    input  rv_pkg::word_t       mem_result,
    input  rv_pkg::word_t       wb_result,
    input  rv_pkg::word_t       load_data,
    input  rv_pkg::fwd_sel_t    sel_a,
    input  rv_pkg::fwd_sel_t    sel_b,
    input  rv_pkg::fwd_sel_t    sel_store,
    output rv_pkg::word_t       result,
    output rv_pkg::word_t       store_data,
    output logic                redirect,
    output rv_pkg::word_t       target
);
    rv_pkg::word_t a, b, alu_out;
    logic          br_eq, br_lt, br_ltu, br_cond;

    function automatic rv_pkg::word_t fwd_mux(input rv_pkg::fwd_sel_t sel,
                                              input rv_pkg::word_t own);
        case (sel)
            rv_pkg::fwd_from_mem:  fwd_mux = mem_result;
            rv_pkg::fwd_from_wb:   fwd_mux = wb_result;
            rv_pkg::fwd_from_load: fwd_mux = load_data;
            default:               fwd_mux = own;   // Value read in decode
        endcase
    endfunction

    always_comb
    begin
        a          = fwd_mux(sel_a, op_a);
        b          = fwd_mux(sel_b, op_b);
        store_data = fwd_mux(sel_store, store_in);
    end

    //////////////////////////////////////////////////////////////////////////
    // ALU
    always_comb
    begin
        case (ctrl.alu_fun)
            rv_pkg::alu_sub:  alu_out = a - b;
            rv_pkg::alu_sll:  alu_out = a << b[4:0];
            rv_pkg::alu_slt:  alu_out = {31'b0, $signed(a) < $signed(b)};
            rv_pkg::alu_sltu: alu_out = {31'b0, a < b};
            rv_pkg::alu_xor:  alu_out = a ^ b;
            rv_pkg::alu_srl:  alu_out = a >> b[4:0];
            rv_pkg::alu_sra:  alu_out = $signed(a) >>> b[4:0];
            rv_pkg::alu_or:   alu_out = a | b;
            rv_pkg::alu_and:  alu_out = a & b;
            rv_pkg::alu_lui:  alu_out = b;          // U immediate straight through
            default:          alu_out = a + b;      // Also load/store address
        endcase
    end

    // JAL writes its return address
    assign result = (ctrl.opcode == rv_pkg::opc_jal) ? ctrl.pc + 32'd4 : alu_out;

    //////////////////////////////////////////////////////////////////////////
    // Branch condition and redirect
    assign br_eq  = a == b;
    assign br_lt  = $signed(a) < $signed(b);
    assign br_ltu = a < b;

    always_comb
    begin
        case (ctrl.funct3)
            3'b000:  br_cond = br_eq;    // BEQ
            3'b001:  br_cond = !br_eq;   // BNE
            3'b100:  br_cond = br_lt;    // BLT
            3'b101:  br_cond = !br_lt;   // BGE
            3'b110:  br_cond = br_ltu;   // BLTU
            3'b111:  br_cond = !br_ltu;  // BGEU
            default: br_cond = 1'b0;
        endcase
    end

    assign redirect = !ctrl.invalid &&
                      ((ctrl.opcode == rv_pkg::opc_branch && br_cond) ||
                       ctrl.opcode == rv_pkg::opc_jal);
    assign target   = ctrl.pc + imm;   // B or J offset picked in decode

endmodule

// File: src/rv_forward.sv
`timescale 1ns/10ps

module rv_forward (
    input  rv_pkg::stage_ctrl_t ex_ctrl,
    input  rv_pkg::stage_ctrl_t mem_ctrl,
    input  rv_pkg::stage_ctrl_t wb_ctrl,
    output rv_pkg::fwd_sel_t    sel_a,
    output rv_pkg::fwd_sel_t    sel_b,
    output rv_pkg::fwd_sel_t    sel_store
);
    logic b_is_reg;  // op_b carries rs2 rather than an immediate

    // MEM is younger than WB, so it is checked first
    function automatic rv_pkg::fwd_sel_t pick(input rv_pkg::reg_addr_t src, input logic used);
        pick = rv_pkg::fwd_none;
        if (used && src != '0)
        begin
            if (mem_ctrl.reg_write && !mem_ctrl.mem_read && mem_ctrl.rd == src)
                pick = rv_pkg::fwd_from_mem;   // Load in MEM is covered by the stall
            else if (wb_ctrl.reg_write && wb_ctrl.rd == src)
                pick = wb_ctrl.ld_haz ? rv_pkg::fwd_from_load : rv_pkg::fwd_from_wb;
        end
    endfunction

    assign b_is_reg = ex_ctrl.opcode == rv_pkg::opc_op || ex_ctrl.opcode == rv_pkg::opc_branch;

    always_comb
    begin
        sel_a     = pick(ex_ctrl.rs1, ex_ctrl.rs1_used);
        sel_b     = pick(ex_ctrl.rs2, ex_ctrl.rs2_used && b_is_reg);
        sel_store = pick(ex_ctrl.rs2, ex_ctrl.rs2_used && ex_ctrl.opcode == rv_pkg::opc_store);
    end

endmodule

// File: src/rv_memory.sv
`timescale 1ns/10ps
`include "rv_config.svh"

module rv_memory (
    input  logic          CLK,
    input  logic          imem_we,
    input  rv_pkg::word_t imem_addr,   // Word index
    input  rv_pkg::word_t imem_wdata,
    input  rv_pkg::word_t fetch_pc,
    input  rv_pkg::word_t addr,        // Byte address from MEM stage
    input  rv_pkg::word_t wdata,
    input  logic          we,
    input  rv_pkg::word_t io_in,
    output rv_pkg::word_t instr,
    output rv_pkg::word_t rdata,
    output rv_pkg::word_t io_addr,
    output rv_pkg::word_t io_wdata,
    output logic          io_wr
);
    localparam int IMEM_AW = $clog2(`RV_IMEM_WORDS);
    localparam int DMEM_AW = $clog2(`RV_DMEM_WORDS);

    rv_pkg::word_t      imem [`RV_IMEM_WORDS];
    rv_pkg::word_t      dmem [`RV_DMEM_WORDS];
    logic               io_sel;
    logic [DMEM_AW-1:0] d_idx;

    assign io_sel = addr[`RV_IO_BIT];
    assign d_idx  = addr[DMEM_AW+1:2];

    // Program load port
    always_ff @(posedge CLK)
    begin
        if (imem_we)
            imem[imem_addr[IMEM_AW-1:0]] <= imem_wdata;
    end

    assign instr = imem[fetch_pc[IMEM_AW+1:2]];  // Byte PC to word index

    always_ff @(posedge CLK)
    begin
        if (we && !io_sel)
            dmem[d_idx] <= wdata;
    end

    assign rdata = io_sel ? io_in : dmem[d_idx];

    //////////////////////////////////////////////////////////////////////////
    // I/O window
    assign io_addr  = addr;
    assign io_wdata = wdata;
    assign io_wr    = we && io_sel;  // One strobe per store

endmodule

// File: src/rv_pkg.sv
package rv_pkg;

    typedef logic [31:0] word_t;     // Data or byte address
    typedef logic [4:0]  reg_addr_t; // x0..x31

    // RV32I major opcodes kept by this core
    typedef enum logic [6:0] {
        opc_lui    = 7'b0110111,
        opc_jal    = 7'b1101111,
        opc_branch = 7'b1100011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_op_imm = 7'b0010011,
        opc_op     = 7'b0110011,
        opc_nop    = 7'b0000000
    } opcode_t;

    // {funct7[5], funct3}, with lui-copy on a spare code
    typedef enum logic [3:0] {
        alu_add  = 4'b0000,
        alu_sll  = 4'b0001,
        alu_slt  = 4'b0010,
        alu_sltu = 4'b0011,
        alu_xor  = 4'b0100,
        alu_srl  = 4'b0101,
        alu_or   = 4'b0110,
        alu_and  = 4'b0111,
        alu_sub  = 4'b1000,
        alu_lui  = 4'b1001,
        alu_sra  = 4'b1101
    } alu_fun_t;

    typedef enum logic [1:0] {
        fwd_none      = 2'b00,
        fwd_from_mem  = 2'b01,
        fwd_from_wb   = 2'b10,
        fwd_from_load = 2'b11
    } fwd_sel_t;

    // Per-instruction control, carried from decode to writeback
    typedef struct packed {
        opcode_t   opcode;
        reg_addr_t rs1;
        logic      rs1_used;
        reg_addr_t rs2;
        logic      rs2_used;
        reg_addr_t rd;
        alu_fun_t  alu_fun;
        logic      mem_write;
        logic      mem_read;
        logic      reg_write;
        logic      wb_sel;    // 0 ALU or link, 1 load data
        logic      ld_haz;    // Load into a nonzero rd
        word_t     pc;
        logic [2:0] funct3;
        logic      invalid;
        logic      br_taken;  // Set on entry to MEM when this slot redirected
    } stage_ctrl_t;

endpackage

// File: src/rv_regfile.sv
`timescale 1ns/10ps

module rv_regfile (
    input  logic              CLK,
    input  rv_pkg::reg_addr_t rs1_addr,
    input  rv_pkg::reg_addr_t rs2_addr,
    input  rv_pkg::reg_addr_t wr_addr,
    input  rv_pkg::word_t     wr_data,
    input  logic              wr_en,
    output rv_pkg::word_t     rs1_data,
    output rv_pkg::word_t     rs2_data
);
    rv_pkg::word_t regs [32]; // x0 is never written

    always_ff @(posedge CLK)
    begin
        if (wr_en && wr_addr != '0)
            regs[wr_addr] <= wr_data;
    end

    // Write-through so decode sees the value retiring this cycle
    assign rs1_data = (rs1_addr == '0) ? '0 :
                      (wr_en && wr_addr == rs1_addr) ? wr_data : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 :
                      (wr_en && wr_addr == rs2_addr) ? wr_data : regs[rs2_addr];

endmodule

// File: verif/otter_pipe_tb.sv
`timescale 1ns/10ps
`include "rv_config.svh"

module otter_pipe_tb;

    localparam int            MAX_CYCLES = 3000;  // Six tests run in about 500 cycles
    localparam rv_pkg::word_t IO_BASE    = 32'h1 << `RV_IO_BIT;

    // RV32I major opcodes
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    logic          CLK;
    logic          rst_n;
    logic          run;
    logic          imem_we;
    rv_pkg::word_t imem_addr;
    rv_pkg::word_t imem_wdata;
    rv_pkg::word_t io_in;
    rv_pkg::word_t io_addr;
    rv_pkg::word_t io_wdata;
    logic          io_wr;

    rv_pkg::word_t prog[$];       // Program being assembled
    rv_pkg::word_t exp_addr[$];   // Expected io_wr sequence in order
    rv_pkg::word_t exp_data[$];
    rv_pkg::word_t lcg_state = 32'h6d346489;
    int            cycles = 0;

    otter_pipe_top UUT (
        .CLK(CLK), .rst_n(rst_n), .run(run), .imem_we(imem_we), .imem_addr(imem_addr),
        .imem_wdata(imem_wdata), .io_in(io_in),
        .io_addr(io_addr), .io_wdata(io_wdata), .io_wr(io_wr)
    );

    initial
    begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;   // 20 ns period
    end

    // Watchdog on total run length
    always @(posedge CLK)
    begin
        cycles++;
        if (cycles >= MAX_CYCLES)
            abort_run("Timeout: the tests did not finish within the cycle limit");
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reporting and compare

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Checks failed");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic check_word(input string name, input rv_pkg::word_t expected,
                              input rv_pkg::word_t actual);
        if (actual !== expected)
            abort_run($sformatf("FAIL %s: expected %h, actual %h", name, expected, actual));
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected)
            abort_run($sformatf("FAIL %s: expected %b, actual %b", name, expected, actual));
    endtask

    function automatic rv_pkg::word_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic rv_pkg::word_t sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // RV32I instruction encoders

    function automatic rv_pkg::word_t lui(input rv_pkg::reg_addr_t rd, input rv_pkg::word_t imm20);
        return {imm20[19:0], rd, OPC_LUI};
    endfunction

    function automatic rv_pkg::word_t addi(input rv_pkg::reg_addr_t rd,
                                           input rv_pkg::reg_addr_t rs1, input rv_pkg::word_t imm);
        return {imm[11:0], rs1, 3'b000, rd, OPC_OP_IMM};
    endfunction

    function automatic rv_pkg::word_t lw(input rv_pkg::reg_addr_t rd,
                                         input rv_pkg::reg_addr_t rs1, input rv_pkg::word_t off);
        return {off[11:0], rs1, 3'b010, rd, OPC_LOAD};
    endfunction

    function automatic rv_pkg::word_t sw(input rv_pkg::reg_addr_t rs2,
                                         input rv_pkg::reg_addr_t rs1, input rv_pkg::word_t off);
        return {off[11:5], rs2, rs1, 3'b010, off[4:0], OPC_STORE};
    endfunction

    // fn is {funct7[5], funct3}
    function automatic rv_pkg::word_t rr_op(input logic [3:0] fn, input rv_pkg::reg_addr_t rd,
                                            input rv_pkg::reg_addr_t rs1,
                                            input rv_pkg::reg_addr_t rs2);
        return {1'b0, fn[3], 5'b0, rs2, rs1, fn[2:0], rd, OPC_OP};
    endfunction

    function automatic rv_pkg::word_t branch_op(input logic [2:0] f3, input rv_pkg::reg_addr_t rs1,
                                                input rv_pkg::reg_addr_t rs2,
                                                input rv_pkg::word_t off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic rv_pkg::word_t jal(input rv_pkg::reg_addr_t rd, input rv_pkg::word_t off);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Reference model from the ISA manual

    function automatic rv_pkg::word_t alu_model(input logic [3:0] fn, input rv_pkg::word_t a,
                                                input rv_pkg::word_t b);
        case (fn)
            4'b0000: return a + b;
            4'b1000: return a - b;
            4'b0001: return a << b[4:0];
            4'b0010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            4'b0011: return (a < b) ? 32'd1 : 32'd0;
            4'b0100: return a ^ b;
            4'b0101: return a >> b[4:0];
            4'b1101: return $signed(a) >>> b[4:0];
            4'b0110: return a | b;
            4'b0111: return a & b;
            default: return 'x;
        endcase
    endfunction

    function automatic logic branch_model(input logic [2:0] f3, input rv_pkg::word_t a,
                                          input rv_pkg::word_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;   // BGEU
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Program build, load and result capture

    task automatic emit_li(input rv_pkg::reg_addr_t rd, input rv_pkg::word_t value);
        rv_pkg::word_t upper;
        upper = (value + 32'h800) >> 12;   // Rounded so the signed low part lands on value
        prog.push_back(lui(rd, upper));
        prog.push_back(addi(rd, rd, value));
    endtask

    task automatic expect_io(input rv_pkg::word_t addr, input rv_pkg::word_t data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic start_program();
        prog.delete();
        exp_addr.delete();
        exp_data.delete();
        prog.push_back(lui(31, IO_BASE >> 12));   // x31 = I/O window base
    endtask

    // Reset held during the load so PC restarts at zero
    task automatic load_program();
        int i;
        @(posedge CLK);
        #2;
        run   = 1'b0;
        rst_n = 1'b0;
        for (i = 0; i < prog.size(); i++)
        begin
            imem_we    = 1'b1;
            imem_addr  = i;        // Word index
            imem_wdata = prog[i];
            @(posedge CLK);
            #2;
        end
        imem_we = 1'b0;
        rst_n   = 1'b1;
        run     = 1'b1;
    endtask

    task automatic wait_io(output rv_pkg::word_t addr, output rv_pkg::word_t data);
        @(negedge CLK);
        while (io_wr !== 1'b1)
            @(negedge CLK);
        addr = io_addr;   // Sampled mid-cycle
        data = io_wdata;
    endtask

    task automatic run_program(input string name);
        rv_pkg::word_t got_addr;
        rv_pkg::word_t got_data;
        prog.push_back(jal(0, 0));   // Park on a self loop
        load_program();
        while (exp_data.size() > 0)
        begin
            wait_io(got_addr, got_data);
            check_word({name, " io_addr"}, exp_addr.pop_front(), got_addr);
            check_word({name, " io_wdata"}, exp_data.pop_front(), got_data);
        end
        repeat (10)   // No stray or squashed stores afterwards
        begin
            @(negedge CLK);
            check_bit({name, " io_wr idle"}, 1'b0, io_wr);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests

    task automatic reset_idle_test();
        int i;
        start_program();
        prog.push_back(sw(0, 31, 0));   // Strobes io_wr as soon as the core runs
        for (i = 0; i < 10; i++)
        begin
            @(posedge CLK);
            #2;
            check_bit("reset_idle", 1'b0, io_wr);
            imem_we = 1'b0;
            if (i < prog.size())          // Program written while in reset
            begin
                imem_we    = 1'b1;
                imem_addr  = i;
                imem_wdata = prog[i];
            end
        end
        rst_n = 1'b1;
        repeat (20)   // Run still low
        begin
            @(posedge CLK);
            #2;
            check_bit("reset_idle", 1'b0, io_wr);
        end
    endtask

    task automatic alu_chain_test();
        logic [3:0]    fns [10];
        rv_pkg::word_t a, b, v, k;
        int            i;
        fns = '{4'b0000, 4'b1000, 4'b0100, 4'b0110, 4'b0111,
                4'b0010, 4'b0011, 4'b0001, 4'b0101, 4'b1101};
        start_program();
        a = lcg_next();
        b = lcg_next();
        emit_li(1, a);
        emit_li(2, b);
        prog.push_back(addi(3, 1, 0));
        v = a;
        for (i = 0; i < 10; i++)
        begin
            k = lcg_next();
            k = sext12(k[31:20]);
            prog.push_back(rr_op(fns[i], 3, 3, 2));  // x3 two back via WB
            prog.push_back(addi(3, 3, k));          // x3 one back via MEM
            prog.push_back(sw(3, 31, 4 * i));       // Store data from MEM
            v = alu_model(fns[i], v, b) + k;
            expect_io(IO_BASE + 4 * i, v);
        end
        run_program("alu_chain");
    endtask

    task automatic load_use_test();
        rv_pkg::word_t w, c;
        w = lcg_next();
        c = lcg_next();
        start_program();
        emit_li(5, w);
        emit_li(6, c);
        prog.push_back(sw(5, 0, 32'h40));
        prog.push_back(lw(7, 0, 32'h40));
        prog.push_back(rr_op(4'b0000, 8, 7, 6));   // Stalls one cycle on x7
        prog.push_back(sw(8, 31, 0));
        prog.push_back(lw(9, 0, 32'h40));
        prog.push_back(sw(9, 31, 4));              // Load feeds store data
        expect_io(IO_BASE, w + c);
        expect_io(IO_BASE + 4, w);
        run_program("load_use");
    endtask

    task automatic branch_test();
        logic [2:0]    f3s [6];
        rv_pkg::word_t ops_a [3];
        rv_pkg::word_t ops_b [3];
        int            i, j, idx;
        f3s   = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        ops_a = '{32'd7, 32'hFFFF_FFFB, 32'd3};   // Equal, less, greater (signed)
        ops_b = '{32'd7, 32'd3, 32'hFFFF_FFFB};
        start_program();
        idx = 0;
        for (i = 0; i < 6; i++)
        begin
            for (j = 0; j < 3; j++)
            begin
                prog.push_back(addi(14, 0, idx));
                prog.push_back(addi(10, 0, ops_a[j]));
                prog.push_back(addi(11, 0, ops_b[j]));
                prog.push_back(branch_op(f3s[i], 10, 11, 12));
                prog.push_back(sw(10, 31, 8));    // Slot 1
                prog.push_back(sw(11, 31, 12));   // Slot 2
                prog.push_back(sw(14, 31, 16));   // Target
                if (!branch_model(f3s[i], ops_a[j], ops_b[j]))
                begin
                    expect_io(IO_BASE + 8, ops_a[j]);
                    expect_io(IO_BASE + 12, ops_b[j]);
                end
                expect_io(IO_BASE + 16, idx);
                idx++;
            end
        end
        run_program("branch");
    endtask

    task automatic jal_test();
        rv_pkg::word_t pc1, pc2;
        start_program();
        pc1 = `RV_RESET_PC + 4 * prog.size();
        prog.push_back(jal(5, 12));
        prog.push_back(sw(0, 31, 0));      // Skipped
        prog.push_back(sw(31, 31, 4));     // Skipped
        prog.push_back(sw(5, 31, 8));
        pc2 = `RV_RESET_PC + 4 * prog.size();
        prog.push_back(jal(6, 12));
        prog.push_back(sw(0, 31, 12));     // Skipped
        prog.push_back(sw(0, 31, 16));     // Skipped
        prog.push_back(sw(6, 31, 20));
        expect_io(IO_BASE + 8, pc1 + 4);
        expect_io(IO_BASE + 20, pc2 + 4);
        run_program("jal");
    endtask

    task automatic io_load_test();
        rv_pkg::word_t value;
        value = lcg_next();
        @(posedge CLK);
        #2;
        io_in = value;
        start_program();
        prog.push_back(lw(6, 31, 0));      // Read through the window
        prog.push_back(addi(6, 6, 1));     // Load-use stall
        prog.push_back(sw(6, 31, 4));
        expect_io(IO_BASE + 4, value + 1);
        run_program("io_load");
    endtask

    initial
    begin
        rst_n      = 1'b0;
        run        = 1'b0;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;
        io_in      = '0;
        reset_idle_test();
        alu_chain_test();
        load_use_test();
        branch_test();
        jal_test();
        io_load_test();
        $display("All checks passed");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+src
src/rv_pkg.sv
src/rv_regfile.sv
src/rv_decode.sv
src/rv_forward.sv
src/rv_execute.sv
src/rv_memory.sv
src/otter_pipe_top.sv
verif/otter_pipe_tb.sv
